/* Bender.yml */
package:
  name: dma_tile

sources:
  - include_dirs:
      - .
    files:
      - dma_pkg.sv
      - dma_if.sv
      - dma_wb_decode.sv
      - dma_request_table.sv
      - dma_copy_engine.sv
      - dma_local_mem.sv
      - dma_top.sv
  - target: test
    files:
      - dma_props.sv
      - dma_tb.sv

/* dma_consts.svh */
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// Request table geometry
`define DMA_TABLE_ENTRIES 4
`define DMA_TABLE_PTRWIDTH 2

// Local memory geometry, word addressed
`define DMA_MEM_WORDS 256
`define DMA_MEM_AWIDTH 8

// One select bit per descriptor field
`define DMA_REQMASK_WIDTH 4

// Byte offsets inside a 32-byte table entry
`define DMA_OFS_LADDR 5'h00
`define DMA_OFS_SIZE 5'h04
`define DMA_OFS_RADDR 5'h08
`define DMA_OFS_CTRL 5'h0C
`define DMA_OFS_STATUS 5'h14

// Set in the bus address for the memory window
`define DMA_MEM_WINDOW_BIT 12

`endif

/* dma_copy_engine.sv */
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_copy_engine import dma_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  dma_job_if.engine job,
  dma_mem_if.master mem
);

  dma_eng_state_t state_q;
  dma_eng_state_t state_d;
  dma_pos_t       pos_q;
  dma_pos_t       pick_pos;
  logic           pick_valid;
  dma_req_t       req_q;
  dma_size_t      cnt_q;
  dma_maddr_t     src_addr;
  dma_maddr_t     dst_addr;
  logic           last_word;

  ////////////////////////////////////////////////////////////////////////////
  // Job selection

  // Lowest pending index wins
  always_comb begin
    pick_valid = 1'b0;
    pick_pos   = '0;
    for (int i = `DMA_TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (job.pending[i]) begin
        pick_valid = 1'b1;
        pick_pos   = dma_pos_t'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM

  assign last_word = ((cnt_q + 1'b1) == req_q.size);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ENG_IDLE: begin
        if (pick_valid) begin
          state_d = ENG_LOAD;
        end
      end
      // Empty job skips the copy loop
      ENG_LOAD:   state_d = (job.req.size == '0) ? ENG_FINISH : ENG_READ;
      ENG_READ:   state_d = ENG_WRITE;
      ENG_WRITE:  state_d = last_word ? ENG_FINISH : ENG_READ;
      ENG_FINISH: state_d = ENG_IDLE;
      default:    state_d = ENG_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= ENG_IDLE;
      pos_q   <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // Hold the index for the whole job
      if (state_q == ENG_IDLE && pick_valid) begin
        pos_q <= pick_pos;
      end
      // Word counter advances after each write
      if (state_q == ENG_LOAD) begin
        cnt_q <= '0;
      end else if (state_q == ENG_WRITE) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Descriptor snapshot
  always_ff @(posedge clk) begin
    if (state_q == ENG_LOAD) begin
      req_q <= job.req;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory port B

  // Direction picks source and destination, wrap modulo 256
  assign src_addr = dma_maddr_t'((req_q.dir ? req_q.laddr : req_q.raddr)
                                 + cnt_q[`DMA_MEM_AWIDTH-1:0]);
  assign dst_addr = dma_maddr_t'((req_q.dir ? req_q.raddr : req_q.laddr)
                                 + cnt_q[`DMA_MEM_AWIDTH-1:0]);

  assign mem.en   = (state_q == ENG_READ) | (state_q == ENG_WRITE);
  assign mem.we   = (state_q == ENG_WRITE);
  assign mem.addr = (state_q == ENG_WRITE) ? dst_addr : src_addr;
  // Read data from the previous cycle goes straight back out
  assign mem.wdata = mem.rdata;

  // Table handshake
  assign job.job_pos = pos_q;
  assign job.done_en = (state_q == ENG_FINISH);

endmodule

/* dma_if.sv */
`timescale 1ns/1ps
`include "dma_consts.svh"

// Bus decode to request table
interface dma_table_wr_if import dma_pkg::*; ();
  dma_req_t req;
  dma_pos_t pos;
  dma_sel_t select;
  logic     write_en;
  // Status word write and read strobes
  logic     valid_en;
  logic     validrd_en;
  // Flags of the entry at pos
  logic     status_done;
  logic     status_valid;

  modport bus (
    output req, pos, select, write_en, valid_en, validrd_en,
    input  status_done, status_valid
  );
  modport tbl (
    input  req, pos, select, write_en, valid_en, validrd_en,
    output status_done, status_valid
  );
endinterface

// Request table to copy engine
interface dma_job_if import dma_pkg::*; ();
  logic [`DMA_TABLE_ENTRIES-1:0] pending;
  dma_req_t req;
  dma_pos_t job_pos;
  logic     done_en;

  modport tbl (output pending, req, input job_pos, done_en);
  modport engine (input pending, req, output job_pos, done_en);
endinterface

// One synchronous memory port, read data one cycle after en
interface dma_mem_if import dma_pkg::*; ();
  logic       en;
  logic       we;
  dma_maddr_t addr;
  dma_word_t  wdata;
  dma_word_t  rdata;

  modport master (output en, we, addr, wdata, input rdata);
  modport mem (input en, we, addr, wdata, output rdata);
endinterface

/* dma_local_mem.sv */
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_local_mem import dma_pkg::*; (
  input  logic   clk,
  dma_mem_if.mem port_a,
  dma_mem_if.mem port_b
);

  // Word storage, contents undefined after reset
  dma_word_t mem_q [`DMA_MEM_WORDS];

  // Both ports in one process
  // Port B write wins on an address clash
  always_ff @(posedge clk) begin
    // Port A, bus window
    if (port_a.en) begin
      if (port_a.we) begin
        mem_q[port_a.addr] <= port_a.wdata;
      end else begin
        port_a.rdata <= mem_q[port_a.addr];
      end
    end
    // Port B, copy engine
    if (port_b.en) begin
      if (port_b.we) begin
        mem_q[port_b.addr] <= port_b.wdata;
      end else begin
        port_b.rdata <= mem_q[port_b.addr];
      end
    end
  end

endmodule

/* dma_pkg.sv */
`include "dma_consts.svh"

package dma_pkg;

  // Bus side words
  typedef logic [31:0] dma_word_t;
  typedef logic [31:0] dma_addr_t;

  // Word index into the local memory
  typedef logic [`DMA_MEM_AWIDTH-1:0] dma_maddr_t;

  // One extra bit so a full 256-word copy fits
  typedef logic [`DMA_MEM_AWIDTH:0] dma_size_t;

  // Table index and field select mask
  typedef logic [`DMA_TABLE_PTRWIDTH-1:0] dma_pos_t;
  typedef logic [`DMA_REQMASK_WIDTH-1:0] dma_sel_t;

  // Descriptor record
  // dir low copies raddr to laddr, dir high copies laddr to raddr
  typedef struct packed {
    dma_maddr_t laddr;
    dma_size_t  size;
    dma_maddr_t raddr;
    logic       dir;
  } dma_req_t;

  // Copy engine FSM
  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_LOAD,
    ENG_READ,
    ENG_WRITE,
    ENG_FINISH
  } dma_eng_state_t;

endpackage

/* dma_props.sv */
`timescale 1ns/1ps

module dma_props import dma_pkg::*; (
  input logic       clk,
  input logic       reset_i,
  input logic       cyc_i,
  input logic       stb_i,
  input logic       ack_i,
  input logic       eng_en_i,
  input logic       eng_we_i,
  input dma_maddr_t eng_addr_i
);

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone ack

  // Single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
    ack_i |=> !ack_i)
    else $error("ack high in two consecutive cycles");

  // Only after a requested cycle
  ack_after_req: assert property (@(posedge clk) disable iff (reset_i)
    ack_i |-> $past(cyc_i && stb_i))
    else $error("ack without cyc and stb in the cycle before");

  ////////////////////////////////////////////////////////////////////////////
  // Engine memory port

  // Every access has a defined address and direction
  eng_addr_known: assert property (@(posedge clk) disable iff (reset_i)
    eng_en_i |-> !$isunknown({eng_we_i, eng_addr_i}))
    else $error("engine port access with unknown address or we");

endmodule

/* dma_request_table.sv */
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_request_table import dma_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  dma_table_wr_if.tbl wr,
  dma_job_if.tbl      job
);

  // Descriptor storage
  dma_req_t entry_q [`DMA_TABLE_ENTRIES];

  // Per-entry flags
  logic [`DMA_TABLE_ENTRIES-1:0] valid_q;
  logic [`DMA_TABLE_ENTRIES-1:0] done_q;

  ////////////////////////////////////////////////////////////////////////////
  // Descriptor fields

  // Only the selected field of the addressed entry changes
  always_ff @(posedge clk) begin
    if (wr.write_en) begin
      if (wr.select[0]) begin
        entry_q[wr.pos].laddr <= wr.req.laddr;
      end
      if (wr.select[1]) begin
        entry_q[wr.pos].size <= wr.req.size;
      end
      if (wr.select[2]) begin
        entry_q[wr.pos].raddr <= wr.req.raddr;
      end
      if (wr.select[3]) begin
        entry_q[wr.pos].dir <= wr.req.dir;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid and done flags

  // Later statements win on a same-cycle clash
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      // Engine finished its current job
      if (job.done_en) begin
        done_q[job.job_pos] <= 1'b1;
      end
      // Status write
      // bit 0 high launches, low withdraws the entry
      if (wr.valid_en) begin
        valid_q[wr.pos] <= wr.req.dir;
        if (wr.req.dir) begin
          done_q[wr.pos] <= 1'b0;
        end
      end
      // Status read that sees done retires the entry
      if (wr.validrd_en && done_q[wr.pos]) begin
        valid_q[wr.pos] <= 1'b0;
        done_q[wr.pos]  <= 1'b0;
      end
    end
  end

  // Status of the entry under the bus address
  assign wr.status_done  = done_q[wr.pos];
  assign wr.status_valid = valid_q[wr.pos];

  ////////////////////////////////////////////////////////////////////////////
  // Engine side

  // Launched but not yet finished
  assign job.pending = valid_q & ~done_q;

  // Record of the selected job, no register stage
  assign job.req = entry_q[job.job_pos];

endmodule

/* dma_tb.sv */
`timescale 1ns/1ps

module dma_tb import dma_pkg::*; ();

  localparam int CLK_HALF       = 20;
  localparam int ACK_LIMIT      = 8;
  localparam int POLL_LIMIT     = 600;
  localparam int CYCLES_PER_VEC = 700;

  logic      clk;
  logic      reset_i;
  dma_addr_t wb_addr;
  dma_word_t wb_wdata;
  logic      wb_we;
  logic      wb_cyc;
  logic      wb_stb;
  dma_word_t wb_rdata;
  logic      wb_ack;

  int errors;
  int checks;
  int n_vec;

  dma_top uut (
    .clk       (clk),
    .reset_i   (reset_i),
    .wb_addr_i (wb_addr),
    .wb_dat_i  (wb_wdata),
    .wb_we_i   (wb_we),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_dat_o  (wb_rdata),
    .wb_ack_o  (wb_ack)
  );

  // Ack and engine port checks
  bind dma_top dma_props u_props (
    .clk        (clk),
    .reset_i    (reset_i),
    .cyc_i      (wb_cyc_i),
    .stb_i      (wb_stb_i),
    .ack_i      (wb_ack_o),
    .eng_en_i   (eng_mem.en),
    .eng_we_i   (eng_mem.we),
    .eng_addr_i (eng_mem.addr)
  );

  // 40 ns period
  always #CLK_HALF clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Vector file parsing

  // Next op line after any comment lines starting with #
  task automatic next_vector(input int fd, output string op, output dma_addr_t addr,
                             output dma_word_t data, output logic ok);
    string line;
    int    code;
    ok   = 1'b0;
    op   = "";
    addr = '0;
    data = '0;
    code = $fscanf(fd, " %s", op);
    while (code == 1 && op[0] == "#") begin
      code = $fgets(line, fd);
      code = $fscanf(fd, " %s", op);
    end
    if (code == 1) begin
      code = $fscanf(fd, " %h %h", addr, data);
      ok   = (code == 2);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone master

  // Called on a falling edge and returns on one
  task automatic bus_access(input logic we, input dma_addr_t addr, input dma_word_t wdata,
                            output dma_word_t rdata, output logic acked);
    int waited;
    waited   = 0;
    acked    = 1'b0;
    rdata    = '0;
    wb_addr  = addr;
    wb_wdata = wdata;
    wb_we    = we;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    while (!acked && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited++;
      if (wb_ack) begin
        acked = 1'b1;
        rdata = wb_rdata;
      end
    end
    // Address and we stay put until the ack cycle closes
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    if (!acked) begin
      errors++;
      $display("no ack within %0d cycles for access to address %08h", ACK_LIMIT, addr);
    end
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog

  // Armed once the vector count is known
  initial begin
    @(negedge reset_i);
    #(n_vec * CYCLES_PER_VEC * 2 * CLK_HALF);
    $display("watchdog expired, run exceeded %0d cycles", n_vec * CYCLES_PER_VEC);
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int        fd;
    int        polls;
    string     op;
    dma_addr_t addr;
    dma_word_t data;
    dma_word_t rd;
    logic      ok;
    logic      acked;
    clk      = 1'b0;
    reset_i  = 1'b1;
    wb_addr  = '0;
    wb_wdata = '0;
    wb_we    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    errors   = 0;
    checks   = 0;
    n_vec    = 0;

    // First pass only counts ops for the watchdog
    fd = $fopen("dma_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open dma_vectors.txt for reading");
    end else begin
      next_vector(fd, op, addr, data, ok);
      while (ok) begin
        n_vec++;
        next_vector(fd, op, addr, data, ok);
      end
      $fclose(fd);
      fd = $fopen("dma_vectors.txt", "r");
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    // Ack stays low with no access
    repeat (3) begin
      @(negedge clk);
      checks++;
      if (wb_ack !== 1'b0) begin
        errors++;
        $display("mismatch wb_ack_o expected 0 actual %h", wb_ack);
      end
    end

    if (fd != 0) begin
      next_vector(fd, op, addr, data, ok);
      while (ok) begin
        if (op == "W") begin
          bus_access(1'b1, addr, data, rd, acked);
        end else if (op == "R") begin
          bus_access(1'b0, addr, '0, rd, acked);
          checks++;
          if (acked && rd !== data) begin
            errors++;
            $display("mismatch wb_dat_o at %08h expected %08h actual %08h", addr, data, rd);
          end
        end else if (op == "P") begin
          // Status reads until done shows up
          polls = 0;
          rd    = '0;
          acked = 1'b1;
          while (acked && rd[0] !== 1'b1 && polls < POLL_LIMIT) begin
            bus_access(1'b0, addr, '0, rd, acked);
            polls++;
          end
          checks++;
          if (acked && rd[0] !== 1'b1) begin
            errors++;
            $display("entry status at %08h not done after %0d reads", addr, polls);
          end else if (acked && rd !== data) begin
            errors++;
            $display("mismatch wb_dat_o at %08h expected %08h actual %08h", addr, data, rd);
          end
        end else begin
          errors++;
          $display("unknown operation %s in vectors file", op);
        end
        next_vector(fd, op, addr, data, ok);
      end
      $fclose(fd);
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* dma_top.sv */
`timescale 1ns/1ps

module dma_top import dma_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  dma_addr_t wb_addr_i,
  input  dma_word_t wb_dat_i,
  input  logic      wb_we_i,
  input  logic      wb_cyc_i,
  input  logic      wb_stb_i,
  output dma_word_t wb_dat_o,
  output logic      wb_ack_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Stage links

  dma_table_wr_if tbl_wr ();
  dma_job_if      job ();
  // Bus window and engine each own a memory port
  dma_mem_if      bus_mem ();
  dma_mem_if      eng_mem ();

  ////////////////////////////////////////////////////////////////////////////
  // Stages

  // Wishbone slave
  dma_wb_decode u_decode (
    .clk       (clk),
    .reset_i   (reset_i),
    .wb_addr_i (wb_addr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_we_i   (wb_we_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .tbl       (tbl_wr.bus),
    .mem       (bus_mem.master)
  );

  // Descriptors and flags
  dma_request_table u_table (
    .clk     (clk),
    .reset_i (reset_i),
    .wr      (tbl_wr.tbl),
    .job     (job.tbl)
  );

  // Copy FSM
  dma_copy_engine u_engine (
    .clk     (clk),
    .reset_i (reset_i),
    .job     (job.engine),
    .mem     (eng_mem.master)
  );

  // 256 x 32 storage
  dma_local_mem u_mem (
    .clk    (clk),
    .port_a (bus_mem.mem),
    .port_b (eng_mem.mem)
  );

endmodule

/* dma_vectors.txt */
# op addr data, hex. W write, R read and compare, P poll status until done
# P compares the final status word with data
R 14 0
R 34 0
R 54 0
R 74 0
W 1000 c0de0000
W 1004 c0de0011
W 1008 c0de0022
W 100c c0de0033
W 1010 c0de0044
W 1014 c0de0055
W 1018 c0de0066
W 101c c0de0077
W 13fc ffff00ff
R 1000 c0de0000
R 100c c0de0033
R 1014 c0de0055
R 101c c0de0077
R 13fc ffff00ff
W 0 40
W 4 8
W 8 0
W c 0
W 14 1
P 14 3
R 14 0
R 1100 c0de0000
R 1104 c0de0011
R 1108 c0de0022
R 110c c0de0033
R 1110 c0de0044
R 1114 c0de0055
R 1118 c0de0066
R 111c c0de0077
R 1000 c0de0000
R 101c c0de0077
W 120c 5a5a5a5a
W 20 40
W 24 3
W 28 80
W 2c 1
W 34 1
P 34 3
R 1200 c0de0000
R 1204 c0de0011
R 1208 c0de0022
R 120c 5a5a5a5a
W 0 90
W 4 2
W 8 5
W 24 0
W 40 6
W 44 2
W 48 a0
W 4c 1
W 14 1
W 34 1
W 54 1
P 14 3
P 34 3
P 54 3
R 1240 c0de0055
R 1244 c0de0066
R 1280 c0de0066
R 1284 c0de0077
W 60 c0
W 64 30
W 68 0
W 6c 0
W 20 f8
W 24 1
W 28 0
W 2c 0
W 13e0 0badf00d
W 74 1
W 34 1
W 34 0
R 34 0
P 74 3
R 13e0 0badf00d
R 1300 c0de0000
R 131c c0de0077

/* dma_wb_decode.sv */
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_wb_decode import dma_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  dma_addr_t   wb_addr_i,
  input  dma_word_t   wb_dat_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output dma_word_t   wb_dat_o,
  output logic        wb_ack_o,
  dma_table_wr_if.bus tbl,
  dma_mem_if.master   mem
);

  logic       ack_q;
  logic       start;
  logic       window;
  logic       status_hit;
  logic [4:0] ofs;

  ////////////////////////////////////////////////////////////////////////////
  // Access tracking

  // First cycle of cyc and stb, not the ack cycle itself
  assign start  = wb_cyc_i & wb_stb_i & ~ack_q;
  assign window = wb_addr_i[`DMA_MEM_WINDOW_BIT];
  assign ofs    = wb_addr_i[4:0];
  assign status_hit = ~window & (ofs == `DMA_OFS_STATUS);

  // Single-cycle ack, one cycle after start
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= start;
    end
  end

  assign wb_ack_o = ack_q;

  ////////////////////////////////////////////////////////////////////////////
  // Table side, strobes only in the ack cycle

  // Entry index from bits 6..5
  assign tbl.pos = wb_addr_i[`DMA_TABLE_PTRWIDTH+4:5];

  assign tbl.select[0] = (ofs == `DMA_OFS_LADDR);
  assign tbl.select[1] = (ofs == `DMA_OFS_SIZE);
  assign tbl.select[2] = (ofs == `DMA_OFS_RADDR);
  assign tbl.select[3] = (ofs == `DMA_OFS_CTRL);

  // Each field from the low bits of the write data
  // Bit 0 doubles as dir and as the status launch bit
  assign tbl.req = '{
    laddr: wb_dat_i[`DMA_MEM_AWIDTH-1:0],
    size:  wb_dat_i[`DMA_MEM_AWIDTH:0],
    raddr: wb_dat_i[`DMA_MEM_AWIDTH-1:0],
    dir:   wb_dat_i[0]
  };

  assign tbl.write_en   = ack_q & wb_we_i & ~window & (|tbl.select);
  assign tbl.valid_en   = ack_q & wb_we_i & status_hit;
  assign tbl.validrd_en = ack_q & ~wb_we_i & status_hit;

  ////////////////////////////////////////////////////////////////////////////
  // Memory window on port A

  // Issued in the start cycle so read data lands with ack
  assign mem.en    = start & window;
  assign mem.we    = wb_we_i;
  assign mem.addr  = wb_addr_i[`DMA_MEM_AWIDTH+1:2];
  assign mem.wdata = wb_dat_i;

  // Read mux, zero for unmapped offsets
  always_comb begin
    wb_dat_o = '0;
    if (ack_q && !wb_we_i) begin
      if (window) begin
        wb_dat_o = mem.rdata;
      end else if (status_hit) begin
        // Bit 1 valid, bit 0 done
        wb_dat_o = {30'b0, tbl.status_valid, tbl.status_done};
      end
    end
  end

endmodule

/* list.f */
+incdir+.
dma_pkg.sv
dma_if.sv
dma_wb_decode.sv
dma_request_table.sv
dma_copy_engine.sv
dma_local_mem.sv
dma_top.sv
dma_props.sv
dma_tb.sv
